// File: hw/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Fetch and Wishbone address width.
`define ICACHE_ADDR_W 32

// Associativity.
`define ICACHE_WAYS 4

// 64 sets.
`define ICACHE_INDEX_W 6

// Word position inside a line.
`define ICACHE_WORD_SEL_W 2

`define ICACHE_LINE_WORDS 4

// 16-byte lines.
`define ICACHE_LINE_W 128

// Address bits above index, word select and byte offset.
`define ICACHE_TAG_W 22

`endif

// File: hw/icache_ctrl.sv
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_ctrl import icache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic fetch_valid,
	input icache_addr_t fetch_addr,
	output logic fetch_ready,
	input logic decode_ready,
	input logic flush,
	input logic [`ICACHE_WAYS-1:0] way_hit,
	output icache_addr_t lookup_addr,
	output logic fill_en,
	output logic [$clog2(`ICACHE_WAYS)-1:0] fill_way,
	output logic [`ICACHE_LINE_W-1:0] fill_line,
	output logic resp_load,
	output logic resp_hold,
	output logic resp_clear,
	output logic [`ICACHE_WAYS-1:0] resp_way_hit,
	output logic [`ICACHE_WORD_SEL_W-1:0] resp_word,
	output logic resp_fill_sel,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [`ICACHE_ADDR_W-1:0] wb_adr,
	output logic [3:0] wb_sel,
	input logic [31:0] wb_dat_i,
	input logic wb_ack
);

	localparam int WAY_W = $clog2(`ICACHE_WAYS);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_BEAT = 2'd1; // stb up, waiting for ack.
	localparam logic [1:0] S_GAP = 2'd2;
	localparam logic [1:0] S_FILL = 2'd3; // Line and tag written on the way out.

	logic [1:0] state;
	logic [`ICACHE_WORD_SEL_W-1:0] beat;
	logic [WAY_W-1:0] victim;
	logic [`ICACHE_WAYS-1:0] victim_onehot;
	logic drop;
	icache_addr_t miss_addr;
	icache_addr_t beat_addr;
	logic kill;
	logic lookup_hit;
	logic miss;
	logic fill_deliver;

	assign kill = flush && decode_ready;
	assign lookup_hit = |way_hit;

	// Ways look at the live fetch address, or the missing one during a refill.
	assign lookup_addr = (state == S_IDLE) ? fetch_addr : miss_addr;

	assign miss = (state == S_IDLE) && fetch_valid && !lookup_hit && !kill;

	// The refilled request is answered straight from the fill cycle.
	assign fill_deliver = (state == S_FILL) && !drop && (fetch_addr.raw == miss_addr.raw);

	assign fetch_ready = decode_ready && !flush &&
		(((state == S_IDLE) && lookup_hit) || fill_deliver);

	// Stall and flush rules for the response stage.
	assign resp_load = fetch_valid && fetch_ready;
	assign resp_hold = !decode_ready;
	assign resp_clear = kill;

	assign victim_onehot = {{(`ICACHE_WAYS-1){1'b0}}, 1'b1} << victim;
	assign fill_en = (state == S_FILL);
	assign fill_way = victim;

	assign wb_cyc = (state == S_BEAT) || (state == S_GAP);
	assign wb_stb = (state == S_BEAT);
	assign wb_we = 1'b0;
	assign wb_sel = 4'hf;

	always_comb begin
		beat_addr = miss_addr;
		beat_addr.f.word = beat;
		beat_addr.f.byte_off = 2'b00;
	end

	assign wb_adr = beat_addr.raw;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			beat <= '0;
			victim <= '0;
			drop <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (miss) begin
						state <= S_BEAT;
						beat <= '0;
						drop <= 1'b0;
					end
				end
				S_BEAT: begin
					if (wb_ack) begin
						beat <= beat + 1'b1;
						state <= (beat == '1) ? S_FILL : S_GAP;
					end
				end
				S_GAP: state <= S_BEAT;
				default: begin
					state <= S_IDLE;
					victim <= victim + 1'b1; // Round robin over all sets.
				end
			endcase
			// A flush mid refill still lets the line land.
			if ((state != S_IDLE) && kill) begin
				drop <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (miss) begin
			miss_addr <= fetch_addr;
		end
		if ((state == S_BEAT) && wb_ack) begin
			fill_line[32*beat +: 32] <= wb_dat_i; // Lowest word first.
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			resp_way_hit <= '0;
			resp_word <= '0;
			resp_fill_sel <= 1'b0;
		end else if (resp_load) begin
			resp_way_hit <= fill_deliver ? victim_onehot : way_hit;
			resp_word <= fetch_addr.f.word;
			resp_fill_sel <= fill_deliver;
		end
	end

endmodule

// File: hw/icache_out.sv
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_out (
	input logic clk,
	input logic rst,
	input logic [`ICACHE_LINE_W-1:0] rd_line0,
	input logic [`ICACHE_LINE_W-1:0] rd_line1,
	input logic [`ICACHE_LINE_W-1:0] rd_line2,
	input logic [`ICACHE_LINE_W-1:0] rd_line3,
	input logic [`ICACHE_WAYS-1:0] resp_way_hit,
	input logic [`ICACHE_WORD_SEL_W-1:0] resp_word,
	input logic resp_load,
	input logic resp_hold,
	input logic resp_clear,
	input logic resp_fill_sel,
	output logic inst_valid,
	output logic [31:0] inst
);

	logic [`ICACHE_WAYS-1:0] way_sel;
	logic [`ICACHE_LINE_W-1:0] sel_line;

	// A fill names its way directly; a lookup keeps the lowest hitting way.
	assign way_sel = resp_fill_sel ? resp_way_hit
		: (resp_way_hit & (~resp_way_hit + 1'b1));

	assign sel_line = ({`ICACHE_LINE_W{way_sel[0]}} & rd_line0) |
		({`ICACHE_LINE_W{way_sel[1]}} & rd_line1) |
		({`ICACHE_LINE_W{way_sel[2]}} & rd_line2) |
		({`ICACHE_LINE_W{way_sel[3]}} & rd_line3);

	assign inst = sel_line[32*resp_word +: 32];

	always_ff @(posedge clk) begin
		if (rst) begin
			inst_valid <= 1'b0;
		end else if (resp_hold) begin
			inst_valid <= inst_valid; // Decode stalled.
		end else if (resp_clear) begin
			inst_valid <= 1'b0;
		end else begin
			inst_valid <= resp_load;
		end
	end

endmodule

// File: hw/icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

	// One fetch address, seen either as a bus address or split for lookup.
	typedef union packed {
		logic [`ICACHE_ADDR_W-1:0] raw;
		struct packed {
			logic [`ICACHE_TAG_W-1:0] tag;
			logic [`ICACHE_INDEX_W-1:0] index;
			logic [`ICACHE_WORD_SEL_W-1:0] word;
			logic [1:0] byte_off;
		} f;
	} icache_addr_t;

endpackage

// File: hw/icache_top.sv
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_top import icache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic fetch_valid,
	input logic [`ICACHE_ADDR_W-1:0] fetch_addr,
	output logic fetch_ready,
	input logic decode_ready,
	input logic flush,
	output logic inst_valid,
	output logic [31:0] inst,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [`ICACHE_ADDR_W-1:0] wb_adr,
	output logic [3:0] wb_sel,
	input logic [31:0] wb_dat_i,
	input logic wb_ack
);

	icache_addr_t lookup_addr;
	logic fill_en;
	logic [$clog2(`ICACHE_WAYS)-1:0] fill_way;
	logic [`ICACHE_LINE_W-1:0] fill_line;
	logic resp_load;
	logic resp_hold;
	logic resp_clear;
	logic resp_fill_sel;
	logic [`ICACHE_WAYS-1:0] resp_way_hit;
	logic [`ICACHE_WORD_SEL_W-1:0] resp_word;
	logic [`ICACHE_WAYS-1:0] way_hit;
	logic [`ICACHE_LINE_W-1:0] rd_line [`ICACHE_WAYS];

	icache_ctrl u_ctrl (
		.clk, .rst,
		.fetch_valid, .fetch_addr, .fetch_ready,
		.decode_ready, .flush, .way_hit,
		.lookup_addr, .fill_en, .fill_way, .fill_line,
		.resp_load, .resp_hold, .resp_clear,
		.resp_way_hit, .resp_word, .resp_fill_sel,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_i, .wb_ack
	);

	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		icache_way #(.WAY(w)) u_way (
			.clk, .rst, .lookup_addr, .resp_hold,
			.fill_en, .fill_way, .fill_line,
			.hit(way_hit[w]),
			.rd_line(rd_line[w])
		);
	end

	icache_out u_out (
		.clk, .rst,
		.rd_line0(rd_line[0]),
		.rd_line1(rd_line[1]),
		.rd_line2(rd_line[2]),
		.rd_line3(rd_line[3]),
		.resp_way_hit, .resp_word,
		.resp_load, .resp_hold, .resp_clear, .resp_fill_sel,
		.inst_valid, .inst
	);

endmodule

// File: hw/icache_way.sv
`timescale 1ns/100ps
`include "icache_consts.svh"

module icache_way import icache_pkg::*; #(
	parameter int WAY = 0
) (
	input logic clk,
	input logic rst,
	input icache_addr_t lookup_addr,
	input logic resp_hold,
	input logic fill_en,
	input logic [$clog2(`ICACHE_WAYS)-1:0] fill_way,
	input logic [`ICACHE_LINE_W-1:0] fill_line,
	output logic hit,
	output logic [`ICACHE_LINE_W-1:0] rd_line
);

	localparam int SETS = 1 << `ICACHE_INDEX_W;
	localparam int WAY_W = $clog2(`ICACHE_WAYS);
	localparam logic [WAY_W-1:0] WAY_ID = WAY[WAY_W-1:0];

	logic [SETS-1:0] valid;
	logic [`ICACHE_TAG_W-1:0] tags [SETS];
	logic [`ICACHE_LINE_W-1:0] lines [SETS];
	logic [`ICACHE_INDEX_W-1:0] idx;
	logic wr;

	assign idx = lookup_addr.f.index;
	assign wr = fill_en && (fill_way == WAY_ID); // This way is the victim.

	assign hit = valid[idx] && (tags[idx] == lookup_addr.f.tag);

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else if (wr) begin
			valid[idx] <= 1'b1;
		end
	end

	// Tag and line written together at the end of a refill.
	always_ff @(posedge clk) begin
		if (wr) begin
			tags[idx] <= lookup_addr.f.tag;
			lines[idx] <= fill_line;
		end
	end

	// Registered read, the fresh line passes straight through on a fill.
	always_ff @(posedge clk) begin
		if (!resp_hold) begin
			if (wr) begin
				rd_line <= fill_line;
			end else begin
				rd_line <= lines[idx];
			end
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module icache_tb -Mdir obj_dir -f sim.f

if ./obj_dir/Vicache_tb | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: sim.f
+incdir+hw
hw/icache_pkg.sv
hw/icache_way.sv
hw/icache_ctrl.sv
hw/icache_out.sv
hw/icache_top.sv
tests/icache_sva.sv
tests/icache_tb.sv

// File: tests/icache_sva.sv
`timescale 1ns/100ps

module icache_sva (
	input logic clk,
	input logic rst,
	input logic fetch_valid,
	input logic [31:0] fetch_addr,
	input logic fetch_ready,
	input logic inst_valid,
	input logic [31:0] inst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [31:0] wb_adr,
	input logic [3:0] wb_sel,
	input logic wb_ack
);

	int error_count = 0;
	logic [31:0] acc_addr;
	logic [31:0] exp_inst;

	always_ff @(posedge clk) begin
		if (fetch_valid && fetch_ready) begin
			acc_addr <= fetch_addr; // Last accepted fetch.
		end
	end

	// Memory holds its own word address XOR a fixed key.
	assign exp_inst = {acc_addr[31:2], 2'b00} ^ 32'hA5C3_0000;

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
		else begin
			error_count++;
			$error("wb_stb high outside a wb_cyc cycle");
		end

	a_beat_stable: assert property (@(posedge clk) disable iff (rst)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we))
		else begin
			error_count++;
			$error("Wishbone beat changed before wb_ack");
		end

	a_read_only: assert property (@(posedge clk) disable iff (rst) !wb_we)
		else begin
			error_count++;
			$error("wb_we went high");
		end

	a_sel_full: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_sel == 4'hf)
		else begin
			error_count++;
			$error("wb_sel did not select all four bytes");
		end

	a_inst_data: assert property (@(posedge clk) disable iff (rst)
		inst_valid |-> inst == exp_inst)
		else begin
			error_count++;
			$error("inst differs from the word of the accepted address");
		end

endmodule

// File: tests/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;

	// About 40 refills of under 30 cycles and some 250 hit cycles fit well inside.
	localparam int MAX_CYCLES = 4000;
	localparam logic [31:0] MEM_KEY = 32'hA5C3_0000;

	logic clk = 1'b0;
	logic rst;
	logic fetch_valid;
	logic [31:0] fetch_addr;
	logic fetch_ready;
	logic decode_ready;
	logic flush;
	logic inst_valid;
	logic [31:0] inst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [31:0] wb_adr;
	logic [3:0] wb_sel;
	logic [31:0] wb_dat_i = '0;
	logic wb_ack = 1'b0;

	integer seed;
	int cycle = 0;
	int errors = 0;
	int mon_errors = 0;
	int err_base = 0;
	int tests_failed = 0;
	int line_count = 0;
	int ack_count = 0;
	int resp_count = 0;
	int resp_cycle [512];
	int wait_left = 0;
	logic stb_seen = 1'b0;
	logic cyc_q = 1'b0;
	logic [31:0] acc_q [$];
	logic [31:0] fetch_list [$];
	logic [31:0] rand_list [$];

	icache_top UUT (
		.clk, .rst,
		.fetch_valid, .fetch_addr, .fetch_ready,
		.decode_ready, .flush, .inst_valid, .inst,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_dat_i, .wb_ack
	);

	bind icache_top icache_sva u_sva (
		.clk, .rst, .fetch_valid, .fetch_addr, .fetch_ready,
		.inst_valid, .inst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_ack
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] mem_word(input logic [31:0] adr);
		return {adr[31:2], 2'b00} ^ MEM_KEY;
	endfunction

	function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
		return {tag[21:0], set[5:0], word[1:0], 2'b00};
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input int num, input string what);
		int now_err;
		now_err = errors + mon_errors + UUT.u_sva.error_count;
		if (now_err == err_base) begin
			$display("test %0d, %s: ok", num, what);
		end else begin
			$display("test %0d, %s: %0d errors", num, what, now_err - err_base);
			tests_failed++;
		end
		err_base = now_err;
	endtask

	// Present fetch_list in order and move on at each accepting edge.
	task automatic issue_fetches();
		int i;
		i = 0;
		fetch_valid <= 1'b1;
		fetch_addr <= fetch_list[0];
		while (i < fetch_list.size()) begin
			@(posedge clk);
			if (fetch_ready) begin
				i++;
				if (i < fetch_list.size()) begin
					fetch_addr <= fetch_list[i];
				end else begin
					fetch_valid <= 1'b0;
				end
			end
		end
	endtask

	task automatic wait_responses(input int n);
		while (resp_count < n) @(posedge clk);
	endtask

	// Wishbone memory with 0 to 3 wait cycles per beat.
	always @(posedge clk) begin
		wb_ack <= 1'b0;
		if (wb_stb && !wb_ack && !rst) begin
			if (!stb_seen) begin
				stb_seen = 1'b1;
				wait_left = $random(seed) & 3;
			end
			if (wait_left == 0) begin
				wb_ack <= 1'b1;
				wb_dat_i <= mem_word(wb_adr);
				stb_seen = 1'b0;
			end else begin
				wait_left--;
			end
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle == MAX_CYCLES) begin
			$display("timeout: tests still running after %0d cycles", cycle);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// Counts refills, beats and consumed responses, and pairs each response with its fetch.
	always @(posedge clk) begin
		logic [31:0] exp_addr;
		if (!rst) begin
			cyc_q <= wb_cyc;
			if (wb_cyc && !cyc_q) line_count <= line_count + 1;
			if (wb_ack) ack_count <= ack_count + 1;
			if (inst_valid && decode_ready) begin
				resp_cycle[resp_count] <= cycle;
				resp_count <= resp_count + 1;
				if (acc_q.size() == 0) begin
					$display("at %0t a response came with no accepted fetch", $time);
					mon_errors <= mon_errors + 1;
				end else begin
					exp_addr = acc_q.pop_front();
					assert (inst === mem_word(exp_addr)) else begin
						$display("mismatch at %0t: inst got %0h expected %0h",
							$time, inst, mem_word(exp_addr));
						mon_errors <= mon_errors + 1;
					end
				end
			end
			if (fetch_valid && fetch_ready) acc_q.push_back(fetch_addr);
		end
	end

	initial begin
		int i;
		int total;
		int base_line;
		int base_ack;
		int base_resp;
		int line;
		logic [31:0] line_a;
		logic [31:0] line_b;
		logic [31:0] held;
		seed = 32'h8484_2d7e;
		rst = 1'b1;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		decode_ready = 1'b1;
		flush = 1'b0;
		line_a = make_addr(4, 0, 0);
		line_b = make_addr(7, 9, 1);
		for (i = 0; i < 200; i++) begin
			line = $random(seed) & 15; // 16 lines over sets 20 to 23.
			rand_list.push_back(make_addr(8 + (line >> 2), 20 + (line & 3), $random(seed) & 3));
		end
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		check_eq("wb_cyc", wb_cyc, 0);
		check_eq("inst_valid", inst_valid, 0);
		check_eq("fetch_ready", fetch_ready, 0);
		base_line = line_count;
		base_ack = ack_count;
		base_resp = resp_count;
		fetch_list.delete();
		fetch_list.push_back(line_a);
		issue_fetches();
		wait_responses(base_resp + 1);
		check_eq("wb_cyc rises", line_count - base_line, 1);
		check_eq("wb_ack beats", ack_count - base_ack, 4);
		finish_test(1, "reset state and first miss");

		base_line = line_count;
		base_resp = resp_count;
		fetch_list.delete();
		for (i = 0; i < 4; i++) fetch_list.push_back(line_a + 4 * i);
		issue_fetches();
		wait_responses(base_resp + 4);
		check_eq("wb_cyc rises", line_count - base_line, 0);
		check_eq("inst_valid span", resp_cycle[base_resp + 3] - resp_cycle[base_resp], 3);
		finish_test(2, "back-to-back hits in one line");

		fetch_list.delete();
		for (i = 1; i <= 5; i++) fetch_list.push_back(make_addr(i, 5, 0));
		for (i = 0; i < 2; i++) begin
			base_line = line_count;
			base_resp = resp_count;
			issue_fetches();
			wait_responses(base_resp + 5);
			check_eq("wb_cyc rises", line_count - base_line, 5);
		end
		fetch_list.delete();
		fetch_list.push_back(make_addr(4, 5, 0)); // Filled by the last two refills.
		fetch_list.push_back(make_addr(5, 5, 0));
		base_line = line_count;
		base_resp = resp_count;
		issue_fetches();
		wait_responses(base_resp + 2);
		check_eq("wb_cyc rises", line_count - base_line, 0);
		finish_test(3, "round-robin replacement in one set");

		base_resp = resp_count;
		fetch_list.delete();
		fetch_list.push_back(line_a + 4);
		issue_fetches();
		decode_ready <= 1'b0;
		fetch_valid <= 1'b1;
		fetch_addr <= line_a + 8;
		@(posedge clk);
		held = inst;
		check_eq("inst_valid", inst_valid, 1);
		check_eq("inst", held, mem_word(line_a + 4));
		repeat (5) begin
			@(posedge clk);
			check_eq("inst_valid", inst_valid, 1);
			check_eq("inst", inst, held);
			check_eq("fetch_ready", fetch_ready, 0);
		end
		decode_ready <= 1'b1;
		fetch_list.delete();
		fetch_list.push_back(line_a + 8);
		issue_fetches();
		wait_responses(base_resp + 2);
		finish_test(4, "decode stall");

		base_line = line_count;
		base_ack = ack_count;
		base_resp = resp_count;
		fetch_valid <= 1'b1;
		fetch_addr <= line_b;
		@(posedge clk);
		while (!wb_cyc) @(posedge clk);
		flush <= 1'b1; // Branch redirect in the middle of the refill.
		@(posedge clk);
		flush <= 1'b0;
		while (wb_cyc) @(posedge clk);
		fetch_valid <= 1'b0; // The flushed fetch stayed up through the fill cycle.
		repeat (3) @(posedge clk);
		check_eq("responses after flush", resp_count - base_resp, 0);
		check_eq("wb_ack beats", ack_count - base_ack, 4);
		fetch_list.delete();
		fetch_list.push_back(line_b);
		issue_fetches();
		wait_responses(base_resp + 1);
		check_eq("wb_cyc rises", line_count - base_line, 1);
		finish_test(5, "flush during refill");

		base_resp = resp_count;
		fetch_list = rand_list;
		issue_fetches();
		wait_responses(base_resp + 200);
		check_eq("unanswered fetches", acc_q.size(), 0);
		finish_test(6, "random fetches over four sets");

		total = errors + mon_errors + UUT.u_sva.error_count;
		$display("tests run 6, tests failed %0d, errors %0d", tests_failed, total);
		if (total == 0 && tests_failed == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
